// File: prot_pkg.sv
package prot_pkg;

    // bus widths of the MCU, the shared window and the ROM port
    localparam int mcu_addr_w = 21;
    localparam int main_addr_w = 11;
    localparam int rom_addr_w = 16;
    localparam int byte_w = 8;

    typedef logic [mcu_addr_w-1:0] mcu_addr_t;
    typedef logic [main_addr_w-1:0] main_addr_t;
    typedef logic [rom_addr_w-1:0] rom_addr_t;
    typedef logic [byte_w-1:0] byte_t;

    // game selector, only two boards are decoded
    typedef logic [1:0] game_t;
    localparam game_t game_robocop = 2'd0;
    localparam game_t game_hippodrome = 2'd1;

    // one request for the MCU bus, wr high means write
    typedef struct packed {
        mcu_addr_t addr;
        logic wr;
        byte_t wdata;
    } bus_req_t;

    // bus cycle sequencer states
    typedef enum logic [1:0] {
        idle,
        sx_wait,
        ce_wait
    } seq_state_t;

    // earliest ce comes this many cycles after sx
    localparam int sx_to_ce = 3;

    // irq1 stays low while the hold counter runs down
    localparam logic [7:0] irq_hold = 8'd255;
    localparam main_addr_t irq_trigger_addr = 11'h7ff;

    // Hippodrome pages, compared against addr[20:16] or addr[20:17]
    localparam logic [4:0] rom_page = 5'h00;
    localparam logic [4:0] hip_ram_page = 5'h1f;
    // 18xxxx
    localparam logic [3:0] hip_shd_page = 4'hc;
    // 1cxxxx
    localparam logic [3:0] hip_prot_page = 4'he;

    // protection latch keys and the answers read back
    localparam byte_t prot_key_a = 8'h45;
    localparam byte_t prot_ans_a = 8'h4e;
    localparam byte_t prot_key_b = 8'h92;
    localparam byte_t prot_ans_b = 8'h15;
    localparam logic [12:0] prot_latch_off = 13'd5;

endpackage

// File: mcu_bus_seq.sv
module mcu_bus_seq
    import prot_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  bus_req_t  req,
    input  logic      req_stb,
    output logic      busy,
    output logic      done,
    output byte_t     rdata,
    output mcu_addr_t addr,
    output byte_t     dout,
    output logic      wrn,
    output logic      sx,
    output logic      ce,
    input  byte_t     din,
    input  logic      waitn
);

    seq_state_t state;
    bus_req_t   req_q;
    logic [1:0] cnt;

    // request is held here until ce, so addr and dout stay stable
    always_ff @(posedge clk) begin
        if (state == idle && req_stb) begin
            req_q <= req;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state <= idle;
            sx    <= 1'b0;
            done  <= 1'b0;
            cnt   <= '0;
        end else begin
            sx   <= 1'b0;
            done <= 1'b0;
            case (state)
                idle: begin
                    if (req_stb) begin
                        // sx goes out the cycle after the strobe
                        sx    <= 1'b1;
                        cnt   <= 2'(sx_to_ce - 1);
                        state <= sx_wait;
                    end
                end
                sx_wait: begin
                    // three cycles from sx, counting the sx cycle itself
                    if (cnt == 2'd0) begin
                        state <= ce_wait;
                    end else begin
                        cnt <= cnt - 2'd1;
                    end
                end
                ce_wait: begin
                    // ce stays off while the decoder holds waitn low
                    if (waitn) begin
                        done  <= 1'b1;
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // read data is taken in the ce cycle
    always_ff @(posedge clk) begin
        if (ce) begin
            rdata <= din;
        end
    end

    assign ce   = (state == ce_wait) && waitn;
    assign busy = state != idle;
    assign addr = req_q.addr;
    assign dout = req_q.wdata;
    // write strobe only while a write cycle is open
    assign wrn  = !(busy && req_q.wr);

endmodule

// File: shared_ram.sv
module shared_ram
    import prot_pkg::*;
(
    input  logic       clk,
    input  main_addr_t main_addr,
    input  byte_t      main_dout,
    input  logic       main_we,
    output byte_t      main_din,
    input  main_addr_t shd_addr,
    input  byte_t      shd_dout_in,
    input  logic       shd_we,
    output byte_t      shd_dout
);

    // 2 kB window seen by both CPUs
    byte_t mem [2**main_addr_w];

    always_ff @(posedge clk) begin
        if (main_we) begin
            mem[main_addr] <= main_dout;
        end
        // MCU write comes last, it wins a same-address collision
        if (shd_we) begin
            mem[shd_addr] <= shd_dout_in;
        end
    end

    // registered reads on both sides
    always_ff @(posedge clk) begin
        main_din <= mem[main_addr];
        shd_dout <= mem[shd_addr];
    end

endmodule

// File: prot_decode.sv
module prot_decode
    import prot_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  game_t      game_id,
    input  logic       lvbl,
    input  mcu_addr_t  addr,
    input  byte_t      dout,
    input  logic       wrn,
    input  logic       sx,
    input  logic       ce,
    output byte_t      din,
    output logic       waitn,
    input  logic       main_cs,
    input  main_addr_t main_addr,
    output main_addr_t shd_addr,
    output logic       shd_we,
    input  byte_t      shd_dout,
    output rom_addr_t  mcu_rom_addr,
    output logic       mcu_rom_cs,
    input  byte_t      mcu_rom_data,
    input  logic       mcu_rom_ok,
    output logic       irq1_n,
    output logic       irq2_n
);

    logic rom_cs;
    logic ram_cs;
    logic shd_cs;
    logic prot_cs;
    logic rom_seen;
    logic ram_we;
    logic set_irq;
    byte_t prot_st;
    byte_t prot_ans;
    byte_t ram_q;
    logic [7:0] irq_cnt;

    // local work RAM of the MCU
    byte_t ram [2**main_addr_w];

    // selects are taken at sx and dropped with ce
    // the address is already stable when sx is high
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            rom_cs  <= 1'b0;
            ram_cs  <= 1'b0;
            shd_cs  <= 1'b0;
            prot_cs <= 1'b0;
        end else if (sx) begin
            rom_cs <= addr[20:16] == rom_page;
            if (game_id == game_hippodrome) begin
                ram_cs  <= addr[20:16] == hip_ram_page;
                shd_cs  <= addr[20:17] == hip_shd_page;
                prot_cs <= addr[20:17] == hip_prot_page;
            end else begin
                // Robocop splits the top half on bit 13
                ram_cs  <= addr[20] & ~addr[13];
                shd_cs  <= addr[20] & addr[13];
                prot_cs <= 1'b0;
            end
        end else if (ce) begin
            rom_cs  <= 1'b0;
            ram_cs  <= 1'b0;
            shd_cs  <= 1'b0;
            prot_cs <= 1'b0;
        end
    end

    // remember the ROM acknowledge for the rest of the cycle
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            rom_seen <= 1'b0;
        end else if (!rom_cs) begin
            rom_seen <= 1'b0;
        end else if (mcu_rom_ok) begin
            rom_seen <= 1'b1;
        end
    end

    // main CPU owns the bus while its select is up
    assign waitn = !main_cs && (!rom_cs || rom_seen);

    assign mcu_rom_cs   = rom_cs;
    assign mcu_rom_addr = addr[15:0];

    // shared window is 2 kB, Robocop mirrors it over the upper bits
    assign shd_addr = addr[10:0];
    assign shd_we   = shd_cs & ~wrn;
    assign ram_we   = ram_cs & ~wrn;

    always_ff @(posedge clk) begin
        if (ram_we) begin
            ram[addr[10:0]] <= dout;
        end
        ram_q <= ram[addr[10:0]];
    end

    // protection latch, only decoded on Hippodrome
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            prot_st <= '0;
        end else if (prot_cs && !wrn && addr[12:0] == prot_latch_off) begin
            prot_st <= dout;
        end
    end

    always_comb begin
        case (prot_st)
            prot_key_a: prot_ans = prot_ans_a;
            prot_key_b: prot_ans = prot_ans_b;
            default:    prot_ans = '0;
        endcase
    end

    // read mux, unmapped space floats high
    always_ff @(posedge clk) begin
        if (ram_cs) begin
            din <= ram_q;
        end else if (shd_cs) begin
            din <= shd_dout;
        end else if (prot_cs) begin
            din <= prot_ans;
        end else if (rom_cs) begin
            din <= mcu_rom_data;
        end else begin
            din <= 8'hff;
        end
    end

    // main CPU touching the last byte of the window raises irq1
    assign set_irq = main_cs && main_addr == irq_trigger_addr;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            irq_cnt <= '0;
            irq1_n  <= 1'b1;
        end else begin
            if (set_irq) begin
                irq_cnt <= irq_hold;
            end else if (irq_cnt != 8'd0) begin
                irq_cnt <= irq_cnt - 8'd1;
            end
            // set wins over the release at the end of the count
            if (set_irq) begin
                irq1_n <= 1'b0;
            end else if (irq_cnt == 8'd1) begin
                irq1_n <= 1'b1;
            end
        end
    end

    // vertical blank interrupt exists on Hippodrome only
    assign irq2_n = !(game_id == game_hippodrome && !lvbl);

endmodule

// File: prot_top.sv
module prot_top
    import prot_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  main_addr_t main_addr,
    input  byte_t      main_dout,
    input  logic       main_cs,
    input  logic       main_wrn,
    output byte_t      main_din,
    input  game_t      game_id,
    input  logic       lvbl,
    input  bus_req_t   req,
    input  logic       req_stb,
    output logic       busy,
    output logic       done,
    output byte_t      rdata,
    output rom_addr_t  mcu_rom_addr,
    output logic       mcu_rom_cs,
    input  byte_t      mcu_rom_data,
    input  logic       mcu_rom_ok,
    output logic       irq1_n,
    output logic       irq2_n
);

    mcu_addr_t  addr;
    byte_t      dout;
    byte_t      din;
    byte_t      shd_dout;
    main_addr_t shd_addr;
    logic       wrn;
    logic       sx;
    logic       ce;
    logic       waitn;
    logic       shd_we;
    logic       main_we;

    // main CPU writes when selected with its write strobe low
    assign main_we = main_cs & ~main_wrn;

    mcu_bus_seq u_seq (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .req_stb (req_stb),
        .busy    (busy),
        .done    (done),
        .rdata   (rdata),
        .addr    (addr),
        .dout    (dout),
        .wrn     (wrn),
        .sx      (sx),
        .ce      (ce),
        .din     (din),
        .waitn   (waitn)
    );

    shared_ram u_shared (
        .clk         (clk),
        .main_addr   (main_addr),
        .main_dout   (main_dout),
        .main_we     (main_we),
        .main_din    (main_din),
        .shd_addr    (shd_addr),
        .shd_dout_in (dout),
        .shd_we      (shd_we),
        .shd_dout    (shd_dout)
    );

    prot_decode u_dec (
        .clk          (clk),
        .rst          (rst),
        .game_id      (game_id),
        .lvbl         (lvbl),
        .addr         (addr),
        .dout         (dout),
        .wrn          (wrn),
        .sx           (sx),
        .ce           (ce),
        .din          (din),
        .waitn        (waitn),
        .main_cs      (main_cs),
        .main_addr    (main_addr),
        .shd_addr     (shd_addr),
        .shd_we       (shd_we),
        .shd_dout     (shd_dout),
        .mcu_rom_addr (mcu_rom_addr),
        .mcu_rom_cs   (mcu_rom_cs),
        .mcu_rom_data (mcu_rom_data),
        .mcu_rom_ok   (mcu_rom_ok),
        .irq1_n       (irq1_n),
        .irq2_n       (irq2_n)
    );

endmodule

// File: prot_checker.sv
module prot_checker
    import prot_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  game_t      game_id,
    input  logic       lvbl,
    input  main_addr_t main_addr,
    input  logic       main_cs,
    input  logic       main_wrn,
    input  byte_t      main_din,
    input  bus_req_t   req,
    input  logic       req_stb,
    input  logic       busy,
    input  logic       done,
    input  byte_t      rdata,
    input  rom_addr_t  mcu_rom_addr,
    input  logic       mcu_rom_cs,
    input  logic       mcu_rom_ok,
    input  logic       irq1_n,
    input  logic       irq2_n,
    input  int         idx,
    input  byte_t      exp_data,
    output int         checks,
    output int         errors
);

    timeunit 1ns;
    timeprecision 1ps;

    // latency counts req_stb to sx and sx to ce and ce to done
    localparam int min_lat = 1 + sx_to_ce + 1;

    logic      active;
    logic      rd;
    logic      rom;
    logic      held;
    logic      main_rd;
    logic      irq_set;
    rom_addr_t rom_addr;
    int        lat;
    int        ok_lat;
    int        irq_low;

    task automatic report_fail(input string msg);
        errors++;
        $display("Fail at %0d ns: entry %0d, %s", $time, idx, msg);
    endtask

    task automatic compare_byte(input string what, input byte_t got, input byte_t want);
        checks++;
        if (got !== want) begin
            report_fail($sformatf("%s read %h, expected %h", what, got, want));
        end
    endtask

    initial begin
        checks = 0;
        errors = 0;
    end

    // DUT outputs are looked at mid cycle on the falling edge
    always @(negedge clk) begin : watch
        int want_lat;
        if (rst) begin
            active = 1'b0;
            main_rd = 1'b0;
            irq_set = 1'b0;
            irq_low = 0;
            checks++;
            if (busy || done || mcu_rom_cs || !irq1_n) begin
                report_fail("outputs not at their reset values");
            end
        end else begin
            // main read data comes one cycle after the select
            if (main_rd) begin
                compare_byte("main CPU", main_din, exp_data);
            end
            main_rd = main_cs && main_wrn;

            // irq1 low right after the trigger and high again after the hold
            if (irq_set) begin
                checks++;
                if (irq1_n !== 1'b0) begin
                    report_fail("irq1_n did not go low after a main access to 7ff");
                end
            end
            irq_set = main_cs && main_addr == irq_trigger_addr;
            irq_low = irq1_n ? 0 : irq_low + 1;
            if (irq_low == irq_hold + 3) begin
                report_fail("irq1_n stayed low past the hold time");
            end

            // vertical blank interrupt only on Hippodrome
            checks++;
            if (irq2_n !== ((game_id == game_hippodrome) ? lvbl : 1'b1)) begin
                report_fail("irq2_n does not follow lvbl and the game");
            end

            if (active) begin
                lat++;
                held = held | main_cs;
                rom = rom | mcu_rom_cs;
                if (mcu_rom_cs) begin
                    checks++;
                    if (mcu_rom_addr !== rom_addr) begin
                        report_fail($sformatf("ROM address %h, expected %h",
                                              mcu_rom_addr, rom_addr));
                    end
                end
                if (mcu_rom_cs && mcu_rom_ok && ok_lat < 0) begin
                    ok_lat = lat;
                end
                if (done) begin
                    active = 1'b0;
                    if (rd) begin
                        compare_byte("MCU", rdata, exp_data);
                    end
                    // an acknowledge is seen one cycle late and ce takes one more
                    want_lat = min_lat;
                    if (rom && ok_lat + 2 > min_lat) begin
                        want_lat = ok_lat + 2;
                    end
                    checks++;
                    if (main_cs) begin
                        report_fail("done while main_cs is still high");
                    end else if (rom && ok_lat < 0) begin
                        report_fail("ROM cycle ended before mcu_rom_ok");
                    end else if (held ? lat < min_lat : lat != want_lat) begin
                        report_fail($sformatf("done after %0d cycles, expected %0d",
                                              lat, want_lat));
                    end
                end
            end
            if (req_stb && !busy) begin
                active = 1'b1;
                lat = 0;
                ok_lat = -1;
                rd = !req.wr;
                rom = 1'b0;
                rom_addr = req.addr[15:0];
                held = main_cs;
            end
        end
    end

endmodule

// File: tb_prot.sv
module tb_prot
    import prot_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // entry kinds for main and MCU accesses, lvbl levels and MCU reads under main_cs
    localparam logic [2:0] k_mw = 3'd0;
    localparam logic [2:0] k_mr = 3'd1;
    localparam logic [2:0] k_cw = 3'd2;
    localparam logic [2:0] k_cr = 3'd3;
    localparam logic [2:0] k_lv = 3'd4;
    localparam logic [2:0] k_hd = 3'd5;
    localparam int max_entries = 64;
    localparam int hold_cycles = 10;

    typedef struct packed {
        logic [2:0] kind;
        game_t      game;
        mcu_addr_t  addr;
        byte_t      data;
        byte_t      exp;
    } entry_t;

    logic       clk;
    logic       rst;
    main_addr_t main_addr;
    byte_t      main_dout;
    logic       main_cs;
    logic       main_wrn;
    byte_t      main_din;
    game_t      game_id;
    logic       lvbl;
    bus_req_t   req;
    logic       req_stb;
    logic       busy;
    logic       done;
    byte_t      rdata;
    rom_addr_t  mcu_rom_addr;
    logic       mcu_rom_cs;
    byte_t      mcu_rom_data;
    logic       mcu_rom_ok;
    logic       irq1_n;
    logic       irq2_n;
    int         idx;
    byte_t      exp_data;
    int         checks;
    int         errors;
    entry_t     tbl [max_entries];
    entry_t     cur;
    int         n_tbl;
    logic [31:0] lfsr;
    logic [2:0] rom_delay;
    int         rom_wait;
    logic       rom_armed;

    prot_top prot_top_inst (.*);

    prot_checker u_checker (.*);

    always #10 clk = ~clk;

    // taps of x^32 + x^22 + x^2 + x + 1 with the new bit entering at the bottom
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // ROM acknowledges 0 to 7 cycles after its select
    always @(posedge clk) begin
        #2;
        if (!mcu_rom_cs) begin
            rom_armed = 1'b0;
            mcu_rom_ok = 1'b0;
            mcu_rom_data = 8'h00;
        end else if (!rom_armed) begin
            rom_armed = 1'b1;
            rom_wait = 0;
            // three bits with one LFSR step each
            repeat (3) begin
                lfsr = lfsr_step(lfsr);
                rom_delay = {rom_delay[1:0], lfsr[0]};
            end
        end
        if (rom_armed && !mcu_rom_ok) begin
            if (rom_wait == rom_delay) begin
                mcu_rom_ok = 1'b1;
                mcu_rom_data = ~mcu_rom_addr[7:0];
            end else begin
                rom_wait++;
            end
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic add_entry(input logic [2:0] kind, input game_t game, input mcu_addr_t addr,
                             input byte_t data, input byte_t exp);
        tbl[n_tbl] = {kind, game, addr, data, exp};
        n_tbl++;
    endtask

    task automatic load_table();
        n_tbl = 0;
        // main writes and MCU reads back in both maps and the Robocop mirror
        add_entry(k_mw, game_robocop, 21'h000010, 8'h5a, 8'h00);
        add_entry(k_cr, game_robocop, 21'h102010, 8'h00, 8'h5a);
        add_entry(k_cr, game_robocop, 21'h13a010, 8'h00, 8'h5a);
        add_entry(k_cr, game_hippodrome, 21'h180010, 8'h00, 8'h5a);
        // MCU writes the window and the main CPU reads it
        add_entry(k_cw, game_robocop, 21'h102020, 8'ha7, 8'h00);
        add_entry(k_mr, game_robocop, 21'h000020, 8'h00, 8'ha7);
        add_entry(k_cw, game_hippodrome, 21'h180030, 8'h3c, 8'h00);
        add_entry(k_mr, game_hippodrome, 21'h000030, 8'h00, 8'h3c);
        // local work RAM and unmapped space
        add_entry(k_cw, game_robocop, 21'h100040, 8'h11, 8'h00);
        add_entry(k_cr, game_robocop, 21'h100040, 8'h00, 8'h11);
        add_entry(k_cw, game_hippodrome, 21'h1f0050, 8'h66, 8'h00);
        add_entry(k_cr, game_hippodrome, 21'h1f0050, 8'h00, 8'h66);
        add_entry(k_cr, game_robocop, 21'h0a0000, 8'h00, 8'hff);
        add_entry(k_cr, game_hippodrome, 21'h100040, 8'h00, 8'hff);
        // protection latch keys and the same address on Robocop hitting RAM
        add_entry(k_cw, game_hippodrome, 21'h1c0005, 8'h45, 8'h00);
        add_entry(k_cr, game_hippodrome, 21'h1c0005, 8'h00, 8'h4e);
        add_entry(k_cw, game_hippodrome, 21'h1c0005, 8'h92, 8'h00);
        add_entry(k_cr, game_hippodrome, 21'h1c0005, 8'h00, 8'h15);
        add_entry(k_cw, game_hippodrome, 21'h1c0005, 8'h33, 8'h00);
        add_entry(k_cr, game_hippodrome, 21'h1c0005, 8'h00, 8'h00);
        add_entry(k_cw, game_robocop, 21'h1c0005, 8'h45, 8'h00);
        add_entry(k_cr, game_robocop, 21'h1c0005, 8'h00, 8'h45);
        // ROM data is the inverted low address byte
        add_entry(k_cr, game_robocop, 21'h000123, 8'h00, 8'hdc);
        add_entry(k_cr, game_hippodrome, 21'h00fe45, 8'h00, 8'hba);
        add_entry(k_cr, game_robocop, 21'h0080a7, 8'h00, 8'h58);
        add_entry(k_cr, game_hippodrome, 21'h000001, 8'h00, 8'hfe);
        // more ROM reads so that a short acknowledge delay comes up
        add_entry(k_cr, game_robocop, 21'h000002, 8'h00, 8'hfd);
        add_entry(k_cr, game_hippodrome, 21'h000c44, 8'h00, 8'hbb);
        add_entry(k_cr, game_robocop, 21'h0012f0, 8'h00, 8'h0f);
        add_entry(k_cr, game_hippodrome, 21'h00ab10, 8'h00, 8'hef);
        // irq1 trigger and lvbl levels
        add_entry(k_mw, game_robocop, 21'h0007ff, 8'h00, 8'h00);
        add_entry(k_lv, game_hippodrome, 21'h000000, 8'h00, 8'h00);
        add_entry(k_lv, game_hippodrome, 21'h000000, 8'h01, 8'h00);
        add_entry(k_lv, game_robocop, 21'h000000, 8'h00, 8'h00);
        // MCU reads while the main CPU holds its select on the same byte
        add_entry(k_mw, game_robocop, 21'h000060, 8'hc3, 8'h00);
        add_entry(k_hd, game_hippodrome, 21'h180060, 8'h00, 8'hc3);
        add_entry(k_hd, game_robocop, 21'h102060, 8'h00, 8'hc3);
    endtask

    // one-cycle main CPU select with read data one cycle later
    task automatic main_access(input entry_t e);
        main_addr = e.addr[10:0];
        main_dout = e.data;
        main_wrn = (e.kind == k_mr);
        main_cs = 1'b1;
        next_cycle();
        main_cs = 1'b0;
        main_wrn = 1'b1;
        next_cycle();
    endtask

    task automatic mcu_access(input entry_t e, input logic hold);
        if (hold) begin
            main_addr = e.addr[10:0];
            main_wrn = 1'b1;
            main_cs = 1'b1;
        end
        req = {e.addr, e.kind == k_cw, e.data};
        req_stb = 1'b1;
        next_cycle();
        req_stb = 1'b0;
        if (hold) begin
            repeat (hold_cycles) next_cycle();
            main_cs = 1'b0;
        end
        // the watchdog covers a bus cycle that never ends
        while (!done) begin
            @(negedge clk);
        end
        next_cycle();
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        main_addr = '0;
        main_dout = '0;
        main_cs = 1'b0;
        main_wrn = 1'b1;
        game_id = game_robocop;
        lvbl = 1'b1;
        req = '0;
        req_stb = 1'b0;
        mcu_rom_data = '0;
        mcu_rom_ok = 1'b0;
        rom_armed = 1'b0;
        rom_delay = '0;
        rom_wait = 0;
        lfsr = 32'h6876;
        idx = 0;
        exp_data = '0;
        load_table();
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        next_cycle();
        for (int i = 0; i < n_tbl; i++) begin
            idx = i;
            cur = tbl[i];
            game_id = cur.game;
            exp_data = cur.exp;
            case (cur.kind)
                k_mw, k_mr: main_access(cur);
                k_cw, k_cr: mcu_access(cur, 1'b0);
                k_hd: mcu_access(cur, 1'b1);
                default: begin
                    lvbl = cur.data[0];
                    repeat (2) next_cycle();
                end
            endcase
        end
        // let the irq1 hold run out
        wait (irq1_n === 1'b1);
        repeat (4) next_cycle();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // bound from the table length plus the irq1 hold
    initial begin
        #1;
        repeat (16 + n_tbl * 400 + 300) @(posedge clk);
        $display("watchdog expired, the test sequence did not finish in time");
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: prot_top.f
prot_pkg.sv
mcu_bus_seq.sv
shared_ram.sv
prot_decode.sv
prot_top.sv
prot_checker.sv
tb_prot.sv

// File: Bender.yml
package:
  name: prot_top

sources:
  - prot_pkg.sv
  - mcu_bus_seq.sv
  - shared_ram.sv
  - prot_decode.sv
  - prot_top.sv
  - target: test
    files:
      - prot_checker.sv
      - tb_prot.sv
